//--- logic/axi_pkg.sv
// axi4 read channel types, burst and response encodings, bus widths
`default_nettype none

package axi_pkg;

    // byte address width
    localparam int ADDR_W = 16;

    // transaction id width
    localparam int ID_W = 4;

    // read data bus width, one full word per beat
    localparam int DATA_W = 32;

    // byte offset bits within one data word
    localparam int WORD_SHIFT = $clog2(DATA_W / 8);

    // arburst encodings
    typedef enum logic [1:0] {
        BURST_FIXED = 2'b00,
        BURST_INCR  = 2'b01,
        BURST_WRAP  = 2'b10
    } burst_t;

    // rresp encodings, only the two in use
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } resp_t;

    // read address channel payload
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        len;
        burst_t            burst;
    } ar_chan_t;

    // read data channel payload, also one buffer entry
    typedef struct packed {
        logic [ID_W-1:0]   id;
        logic [DATA_W-1:0] data;
        resp_t             resp;
        logic              last;
    } r_chan_t;

endpackage

`default_nettype wire

//--- logic/rd_buf_pkg.sv
// read buffer definitions shared by the address gate and the memory slave
`default_nettype none

package rd_buf_pkg;

    // address gate states
    typedef enum logic [0:0] {
        GATE_IDLE = 1'b0,
        GATE_WAIT = 1'b1
    } gate_state_t;

    // longest axi4 burst in beats
    localparam int MAX_BEATS = 256;

endpackage

`default_nettype wire

//--- logic/axi_ar_gate.sv
// read address gate, holds a request until the data buffer can take its burst
`default_nettype none

module axi_ar_gate #(
    parameter int   FIFO_DEPTH = 16,
    parameter logic FIFO_DELAY = 1'b1
) (
    input  wire logic               clk,
    input  wire logic               rst,

    input  wire axi_pkg::ar_chan_t  s_ar,
    input  wire logic               s_ar_valid,
    output logic                    s_ar_ready,

    output axi_pkg::ar_chan_t       m_ar,
    output logic                    m_ar_valid,
    input  wire logic               m_ar_ready,

    input  wire logic               r_done
);

    if (FIFO_DELAY) begin : g_delay

        // room for a full-length burst on top of a full buffer
        localparam int COUNT_W = $clog2(rd_buf_pkg::MAX_BEATS + FIFO_DEPTH) + 1;
        localparam logic [COUNT_W-1:0] DEPTH_C = COUNT_W'(FIFO_DEPTH);

        rd_buf_pkg::gate_state_t state_reg, state_next;

        // beats promised downstream but not yet handed upstream
        logic [COUNT_W-1:0] count_reg, count_next;

        axi_pkg::ar_chan_t ar_reg, ar_next;
        logic              ar_valid_reg, ar_valid_next;
        logic              ar_ready_reg, ar_ready_next;

        logic [7:0]         len_sel;
        logic [COUNT_W-1:0] burst_beats;
        logic               fits;

        assign m_ar       = ar_reg;
        assign m_ar_valid = ar_valid_reg;
        assign s_ar_ready = ar_ready_reg;

        // new request in idle, held one in wait
        assign len_sel     = (state_reg == rd_buf_pkg::GATE_WAIT) ? ar_reg.len : s_ar.len;
        assign burst_beats = COUNT_W'(len_sel) + COUNT_W'(1);
        assign fits        = (count_reg == '0) || (count_reg + burst_beats <= DEPTH_C);

        always_comb begin
            state_next    = state_reg;
            count_next    = count_reg;
            ar_next       = ar_reg;
            ar_valid_next = ar_valid_reg && !m_ar_ready;
            ar_ready_next = ar_ready_reg;

            case (state_reg)
                rd_buf_pkg::GATE_IDLE: begin
                    ar_ready_next = !m_ar_valid || m_ar_ready;
                    if (s_ar_valid && s_ar_ready) begin
                        ar_next       = s_ar;
                        ar_ready_next = 1'b0;
                        if (fits) begin
                            count_next    = count_reg + burst_beats;
                            ar_valid_next = 1'b1;
                        end else begin
                            state_next = rd_buf_pkg::GATE_WAIT;
                        end
                    end
                end
                rd_buf_pkg::GATE_WAIT: begin
                    ar_ready_next = 1'b0;
                    if (fits) begin
                        count_next    = count_reg + burst_beats;
                        ar_valid_next = 1'b1;
                        state_next    = rd_buf_pkg::GATE_IDLE;
                    end
                end
                default: begin
                    state_next = rd_buf_pkg::GATE_IDLE;
                end
            endcase

            // one credit back per beat taken upstream
            if (r_done) begin
                count_next = count_next - COUNT_W'(1);
            end
        end

        always_ff @(posedge clk) begin
            state_reg    <= state_next;
            count_reg    <= count_next;
            ar_reg       <= ar_next;
            ar_valid_reg <= ar_valid_next;
            ar_ready_reg <= ar_ready_next;

            if (rst) begin
                state_reg    <= rd_buf_pkg::GATE_IDLE;
                count_reg    <= '0;
                ar_valid_reg <= 1'b0;
                ar_ready_reg <= 1'b0;
            end
        end

    end else begin : g_bypass

        // straight through, no credit tracking
        assign m_ar       = s_ar;
        assign m_ar_valid = s_ar_valid;
        assign s_ar_ready = m_ar_ready;

    end

endmodule

`default_nettype wire

//--- logic/axi_r_buffer.sv
// read data FIFO with registered memory read and output register
`default_nettype none

module axi_r_buffer #(
    parameter int FIFO_DEPTH = 16
) (
    input  wire logic              clk,
    input  wire logic              rst,

    input  wire axi_pkg::r_chan_t  m_r,
    input  wire logic              m_r_valid,
    output logic                   m_r_ready,

    output axi_pkg::r_chan_t       s_r,
    output logic                   s_r_valid,
    input  wire logic              s_r_ready
);

    localparam int FIFO_AW = $clog2(FIFO_DEPTH);

    axi_pkg::r_chan_t mem [FIFO_DEPTH];

    // extra msb tells full from empty
    logic [FIFO_AW:0] wr_ptr_reg;
    logic [FIFO_AW:0] rd_ptr_reg;

    axi_pkg::r_chan_t rd_data_reg;
    logic             rd_valid_reg;

    axi_pkg::r_chan_t out_reg;
    logic             out_valid_reg;

    logic full;
    logic empty;
    logic write;
    logic read;
    logic store_output;

    assign full  = (wr_ptr_reg[FIFO_AW] != rd_ptr_reg[FIFO_AW]) &&
                   (wr_ptr_reg[FIFO_AW-1:0] == rd_ptr_reg[FIFO_AW-1:0]);
    assign empty = (wr_ptr_reg == rd_ptr_reg);

    assign m_r_ready = !full;
    assign s_r       = out_reg;
    assign s_r_valid = out_valid_reg;

    assign write = m_r_valid && !full;

    // output register loads when empty or being drained
    assign store_output = s_r_ready || !out_valid_reg;

    // read stage refills when its item moves on or it has none
    assign read = (store_output || !rd_valid_reg) && !empty;

    always_ff @(posedge clk) begin
        if (write) begin
            mem[wr_ptr_reg[FIFO_AW-1:0]] <= m_r;
            wr_ptr_reg <= wr_ptr_reg + (FIFO_AW + 1)'(1);
        end

        if (rst) begin
            wr_ptr_reg <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (read) begin
            rd_data_reg <= mem[rd_ptr_reg[FIFO_AW-1:0]];
            rd_ptr_reg  <= rd_ptr_reg + (FIFO_AW + 1)'(1);
        end

        if (store_output || !rd_valid_reg) begin
            rd_valid_reg <= !empty;
        end

        if (rst) begin
            rd_ptr_reg   <= '0;
            rd_valid_reg <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (store_output) begin
            out_reg       <= rd_data_reg;
            out_valid_reg <= rd_valid_reg;
        end

        if (rst) begin
            out_valid_reg <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- logic/axi_rd_fifo.sv
// axi4 read FIFO block, address gate in front of the read data buffer
`default_nettype none

module axi_rd_fifo #(
    parameter int   FIFO_DEPTH = 16,
    parameter logic FIFO_DELAY = 1'b1
) (
    input  wire logic               clk,
    input  wire logic               rst,

    input  wire axi_pkg::ar_chan_t  s_ar,
    input  wire logic               s_ar_valid,
    output logic                    s_ar_ready,
    output axi_pkg::r_chan_t        s_r,
    output logic                    s_r_valid,
    input  wire logic               s_r_ready,

    output axi_pkg::ar_chan_t       m_ar,
    output logic                    m_ar_valid,
    input  wire logic               m_ar_ready,
    input  wire axi_pkg::r_chan_t   m_r,
    input  wire logic               m_r_valid,
    output logic                    m_r_ready
);

    // upstream beat taken, frees one credit
    logic r_done;

    assign r_done = s_r_valid && s_r_ready;

    axi_ar_gate #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .FIFO_DELAY (FIFO_DELAY)
    ) u_ar_gate (
        .clk        (clk),
        .rst        (rst),
        .s_ar       (s_ar),
        .s_ar_valid (s_ar_valid),
        .s_ar_ready (s_ar_ready),
        .m_ar       (m_ar),
        .m_ar_valid (m_ar_valid),
        .m_ar_ready (m_ar_ready),
        .r_done     (r_done)
    );

    axi_r_buffer #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_r_buffer (
        .clk       (clk),
        .rst       (rst),
        .m_r       (m_r),
        .m_r_valid (m_r_valid),
        .m_r_ready (m_r_ready),
        .s_r       (s_r),
        .s_r_valid (s_r_valid),
        .s_r_ready (s_r_ready)
    );

endmodule

`default_nettype wire

//--- logic/axi_ram_rd.sv
// axi4 read slave over a word memory, with a plain load port
`default_nettype none

module axi_ram_rd #(
    parameter int MEM_WORDS = 64
) (
    input  wire logic                        clk,
    input  wire logic                        rst,

    input  wire axi_pkg::ar_chan_t           ar,
    input  wire logic                        ar_valid,
    output logic                             ar_ready,

    output axi_pkg::r_chan_t                 r,
    output logic                             r_valid,
    input  wire logic                        r_ready,

    input  wire logic                        load_en,
    input  wire logic [$clog2(MEM_WORDS)-1:0] load_addr,
    input  wire logic [axi_pkg::DATA_W-1:0]  load_data
);

    localparam int MEM_AW = $clog2(MEM_WORDS);
    localparam int BEAT_W = $clog2(rd_buf_pkg::MAX_BEATS);

    // word index with one spare bit so an incr burst cannot wrap
    localparam int IDX_W = axi_pkg::ADDR_W - axi_pkg::WORD_SHIFT + 1;
    localparam logic [IDX_W-1:0] MEM_LIMIT = IDX_W'(MEM_WORDS);

    logic [axi_pkg::DATA_W-1:0] mem [MEM_WORDS];

    logic busy_reg;

    // current burst
    logic [axi_pkg::ID_W-1:0] id_reg;
    axi_pkg::burst_t          burst_reg;
    logic [IDX_W-1:0]         idx_reg;
    logic [BEAT_W-1:0]        beats_reg;

    axi_pkg::r_chan_t r_reg;
    logic             r_valid_reg;

    logic start;
    logic step;

    // next beat to present
    logic [axi_pkg::ID_W-1:0] beat_id;
    axi_pkg::burst_t          beat_burst;
    logic [IDX_W-1:0]         beat_idx;
    logic [BEAT_W-1:0]        beat_left;
    logic                     beat_err;

    assign ar_ready = !busy_reg;
    assign r        = r_reg;
    assign r_valid  = r_valid_reg;

    assign start = ar_valid && ar_ready;
    assign step  = r_valid_reg && r_ready && !r_reg.last;

    always_comb begin
        if (start) begin
            beat_id    = ar.id;
            beat_burst = ar.burst;
            beat_idx   = {1'b0, ar.addr[axi_pkg::ADDR_W-1:axi_pkg::WORD_SHIFT]};
            beat_left  = ar.len;
        end else begin
            beat_id    = id_reg;
            beat_burst = burst_reg;
            beat_left  = beats_reg - BEAT_W'(1);
            // fixed bursts stay on one word
            if (burst_reg == axi_pkg::BURST_INCR) begin
                beat_idx = idx_reg + IDX_W'(1);
            end else begin
                beat_idx = idx_reg;
            end
        end
    end

    // wrap bursts are not served
    assign beat_err = (beat_idx >= MEM_LIMIT) || (beat_burst == axi_pkg::BURST_WRAP);

    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            busy_reg  <= 1'b1;
            id_reg    <= ar.id;
            burst_reg <= ar.burst;
        end

        if (start || step) begin
            idx_reg     <= beat_idx;
            beats_reg   <= beat_left;
            r_reg.id    <= beat_id;
            r_reg.data  <= beat_err ? '0 : mem[beat_idx[MEM_AW-1:0]];
            r_reg.resp  <= beat_err ? axi_pkg::RESP_SLVERR : axi_pkg::RESP_OKAY;
            r_reg.last  <= (beat_left == '0);
            r_valid_reg <= 1'b1;
        end else if (r_valid_reg && r_ready) begin
            // final beat taken
            r_valid_reg <= 1'b0;
            busy_reg    <= 1'b0;
        end

        if (rst) begin
            busy_reg    <= 1'b0;
            r_valid_reg <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- logic/axi_rd_subsys.sv
// axi4 read subsystem, read FIFO block in front of the memory slave
`default_nettype none

module axi_rd_subsys #(
    parameter int   FIFO_DEPTH = 16,
    parameter logic FIFO_DELAY = 1'b1,
    parameter int   MEM_WORDS  = 64
) (
    input  wire logic                         clk,
    input  wire logic                         rst,

    input  wire axi_pkg::ar_chan_t            s_ar,
    input  wire logic                         s_ar_valid,
    output logic                              s_ar_ready,
    output axi_pkg::r_chan_t                  s_r,
    output logic                              s_r_valid,
    input  wire logic                         s_r_ready,

    input  wire logic                         load_en,
    input  wire logic [$clog2(MEM_WORDS)-1:0] load_addr,
    input  wire logic [axi_pkg::DATA_W-1:0]   load_data
);

    axi_pkg::ar_chan_t m_ar;
    logic              m_ar_valid;
    logic              m_ar_ready;
    axi_pkg::r_chan_t  m_r;
    logic              m_r_valid;
    logic              m_r_ready;

    axi_rd_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .FIFO_DELAY (FIFO_DELAY)
    ) u_rd_fifo (
        .clk        (clk),
        .rst        (rst),
        .s_ar       (s_ar),
        .s_ar_valid (s_ar_valid),
        .s_ar_ready (s_ar_ready),
        .s_r        (s_r),
        .s_r_valid  (s_r_valid),
        .s_r_ready  (s_r_ready),
        .m_ar       (m_ar),
        .m_ar_valid (m_ar_valid),
        .m_ar_ready (m_ar_ready),
        .m_r        (m_r),
        .m_r_valid  (m_r_valid),
        .m_r_ready  (m_r_ready)
    );

    axi_ram_rd #(
        .MEM_WORDS (MEM_WORDS)
    ) u_ram_rd (
        .clk       (clk),
        .rst       (rst),
        .ar        (m_ar),
        .ar_valid  (m_ar_valid),
        .ar_ready  (m_ar_ready),
        .r         (m_r),
        .r_valid   (m_r_valid),
        .r_ready   (m_r_ready),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

endmodule

`default_nettype wire

//--- bench/axi_rd_subsys_tb.sv
// testbench for the axi4 read subsystem, directed bursts against a shadow memory
`default_nettype none

module axi_rd_subsys_tb;

    localparam int FIFO_DEPTH = 16;
    localparam logic FIFO_DELAY = 1'b1;
    localparam int MEM_WORDS = 64;
    localparam int MEM_AW = $clog2(MEM_WORDS);
    localparam int ADDR_W = axi_pkg::ADDR_W;

    // singles, incr, fixed, errors, back-pressure, in flight
    localparam int TOTAL_BEATS = 4 + 8 + 5 + 12 + 40 + 20;
    localparam int WATCHDOG_CYCLES = TOTAL_BEATS * 40 + 2000;

    logic clk;
    logic rst;

    axi_pkg::ar_chan_t s_ar;
    logic              s_ar_valid;
    logic              s_ar_ready;
    axi_pkg::r_chan_t  s_r;
    logic              s_r_valid;
    logic              s_r_ready;

    logic                       load_en;
    logic [MEM_AW-1:0]          load_addr;
    logic [axi_pkg::DATA_W-1:0] load_data;

    logic [axi_pkg::DATA_W-1:0] shadow [MEM_WORDS];
    axi_pkg::r_chan_t expected [$];
    int len_plan [$];
    int burst_lens [$];

    integer seed = 32'ha505d1a2;
    logic   random_ready;
    string  test_name;
    int     beat_errors;
    int     count_errors;

    axi_rd_subsys #(
        .FIFO_DEPTH (FIFO_DEPTH),
        .FIFO_DELAY (FIFO_DELAY),
        .MEM_WORDS  (MEM_WORDS)
    ) UUT (
        .clk        (clk),
        .rst        (rst),
        .s_ar       (s_ar),
        .s_ar_valid (s_ar_valid),
        .s_ar_ready (s_ar_ready),
        .s_r        (s_r),
        .s_r_valid  (s_r_valid),
        .s_r_ready  (s_r_ready),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic compare_r(input string name, input axi_pkg::r_chan_t exp,
                             input axi_pkg::r_chan_t act);
        string exp_text;
        string act_text;
        if (act !== exp) begin
            beat_errors++;
            exp_text = $sformatf("id %0h data %08h resp %0h last %0b",
                                 exp.id, exp.data, exp.resp, exp.last);
            act_text = $sformatf("id %0h data %08h resp %0h last %0b",
                                 act.id, act.data, act.resp, act.last);
            $display("Fail %s: expected %s, actual %s", name, exp_text, act_text);
        end
    endtask

    task automatic compare_count(input string name, input int exp, input int act);
        if (act != exp) begin
            count_errors++;
            $display("Fail %s: expected %0d beats, actual %0d", name, exp, act);
        end
    endtask

    task automatic load_words(input int first, input int count);
        logic [axi_pkg::DATA_W-1:0] word;
        int k;
        for (k = 0; k < count; k++) begin
            word = $random(seed);
            shadow[first + k] = word;
            load_en   <= 1'b1;
            load_addr <= MEM_AW'(first + k);
            load_data <= word;
            @(posedge clk);
        end
        load_en <= 1'b0;
    endtask

    // reference beats follow the burst rules, then the request goes out
    task automatic send_ar(input logic [axi_pkg::ID_W-1:0] id, input int word,
                           input logic [7:0] len, input axi_pkg::burst_t burst);
        axi_pkg::ar_chan_t ar;
        axi_pkg::r_chan_t  beat;
        int idx;
        int k;
        for (k = 0; k <= int'(len); k++) begin
            idx = (burst == axi_pkg::BURST_INCR) ? word + k : word;
            beat.id   = id;
            beat.last = (k == int'(len));
            if (burst == axi_pkg::BURST_WRAP || idx >= MEM_WORDS) begin
                beat.data = '0;
                beat.resp = axi_pkg::RESP_SLVERR;
            end else begin
                beat.data = shadow[idx];
                beat.resp = axi_pkg::RESP_OKAY;
            end
            expected.push_back(beat);
        end
        len_plan.push_back(int'(len) + 1);
        ar.id    = id;
        ar.addr  = ADDR_W'(word << axi_pkg::WORD_SHIFT);
        ar.len   = len;
        ar.burst = burst;
        s_ar       <= ar;
        s_ar_valid <= 1'b1;
        do begin
            @(posedge clk);
        end while (!s_ar_ready);
        s_ar_valid <= 1'b0;
    endtask

    task automatic wait_drain();
        while (expected.size() != 0) begin
            @(posedge clk);
        end
        // room for a stray extra beat to show up
        repeat (4) @(posedge clk);
    endtask

    task automatic check_bursts();
        int k;
        compare_count({test_name, " bursts"}, len_plan.size(), burst_lens.size());
        for (k = 0; k < len_plan.size() && k < burst_lens.size(); k++) begin
            compare_count(test_name, len_plan[k], burst_lens[k]);
        end
        len_plan.delete();
        burst_lens.delete();
    endtask

    task automatic watch_r_channel();
        axi_pkg::r_chan_t exp_beat;
        int burst_beats;
        burst_beats = 0;
        forever begin
            @(posedge clk);
            if (!rst && s_r_valid && s_r_ready) begin
                if (expected.size() == 0) begin
                    beat_errors++;
                    $display("%s: read beat with id %0h arrived with no request outstanding",
                             test_name, s_r.id);
                end else begin
                    exp_beat = expected.pop_front();
                    compare_r(test_name, exp_beat, s_r);
                end
                burst_beats++;
                if (s_r.last) begin
                    burst_lens.push_back(burst_beats);
                    burst_beats = 0;
                end
            end
        end
    endtask

    task automatic drive_r_ready();
        logic [31:0] rnd;
        s_r_ready <= 1'b0;
        forever begin
            @(posedge clk);
            if (random_ready) begin
                rnd = $random(seed);
                s_r_ready <= rnd[0];
            end else begin
                s_r_ready <= 1'b1;
            end
        end
    endtask

    task automatic stop_on_timeout();
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: read responses stopped arriving before all tests ended");
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    task automatic single_reads();
        test_name = "single_reads";
        load_words(0, MEM_WORDS);
        send_ar(4'h1, 0, 8'd0, axi_pkg::BURST_INCR);
        send_ar(4'h2, 17, 8'd0, axi_pkg::BURST_INCR);
        send_ar(4'h3, 42, 8'd0, axi_pkg::BURST_INCR);
        send_ar(4'h4, 63, 8'd0, axi_pkg::BURST_INCR);
        wait_drain();
        check_bursts();
    endtask

    task automatic incr_burst();
        test_name = "incr_burst";
        load_words(8, 8);
        send_ar(4'h5, 8, 8'd7, axi_pkg::BURST_INCR);
        wait_drain();
        check_bursts();
    endtask

    task automatic fixed_burst();
        test_name = "fixed_burst";
        load_words(30, 1);
        send_ar(4'h6, 30, 8'd4, axi_pkg::BURST_FIXED);
        wait_drain();
        check_bursts();
    endtask

    task automatic error_bursts();
        test_name = "error_bursts";
        load_words(60, 4);
        // four words in range, four past the end
        send_ar(4'h7, 60, 8'd7, axi_pkg::BURST_INCR);
        send_ar(4'h8, 4, 8'd3, axi_pkg::BURST_WRAP);
        wait_drain();
        check_bursts();
    endtask

    task automatic back_pressure();
        test_name = "back_pressure";
        load_words(0, MEM_WORDS);
        random_ready = 1'b1;
        send_ar(4'h9, 12, 8'd39, axi_pkg::BURST_INCR);
        while (expected.size() != 0) begin
            @(posedge clk);
        end
        random_ready = 1'b0;
        wait_drain();
        check_bursts();
    endtask

    task automatic in_flight();
        test_name = "in_flight";
        send_ar(4'ha, 4, 8'd2, axi_pkg::BURST_INCR);
        send_ar(4'hb, 20, 8'd0, axi_pkg::BURST_INCR);
        // third burst leaves too little credit, so the gate holds the fourth
        send_ar(4'hc, 33, 8'd11, axi_pkg::BURST_INCR);
        send_ar(4'hd, 50, 8'd3, axi_pkg::BURST_FIXED);
        wait_drain();
        check_bursts();
    endtask

    initial begin
        rst          <= 1'b1;
        s_ar         <= '0;
        s_ar_valid   <= 1'b0;
        load_en      <= 1'b0;
        load_addr    <= '0;
        load_data    <= '0;
        random_ready = 1'b0;
        beat_errors  = 0;
        count_errors = 0;
        test_name    = "reset";
        fork
            drive_r_ready();
            watch_r_channel();
            stop_on_timeout();
        join_none
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        single_reads();
        incr_burst();
        fixed_burst();
        error_bursts();
        back_pressure();
        in_flight();

        $display("errors: %0d in beats, %0d in counts", beat_errors, count_errors);
        if (beat_errors == 0 && count_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- axi_rd_subsys.f
logic/axi_pkg.sv
logic/rd_buf_pkg.sv
logic/axi_ar_gate.sv
logic/axi_r_buffer.sv
logic/axi_rd_fifo.sv
logic/axi_ram_rd.sv
logic/axi_rd_subsys.sv
bench/axi_rd_subsys_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the read subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -f axi_rd_subsys.f --top-module axi_rd_subsys_tb \
    --Mdir obj_dir -o axi_rd_subsys_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/axi_rd_subsys_sim > sim.log 2>&1; cat sim.log

grep -q "TEST RESULT: PASS" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
